// ==== mipsPkg.sv ====
package mipsPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;
  localparam int imemDepth = 256;
  localparam int dmemDepth = 256;
  localparam int imemAddrWidth = $clog2(imemDepth);
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  localparam logic [5:0] opR = 6'b000000;
  localparam logic [5:0] opSlti = 6'b001010;
  localparam logic [5:0] opLw = 6'b100011;
  localparam logic [5:0] opSw = 6'b101011;
  localparam logic [5:0] opBeq = 6'b000100;

  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnSlt = 6'b101010;

  typedef enum logic [1:0] {aluAdd, aluSub, aluSlt} aluOpT;

  typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic memWrite;
    logic memRead;
    logic aluSrc;
    logic regDst;
    logic branch;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] instr;
  } ifIdT;

  typedef struct packed {
    ctrlT ctrl;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic [dataWidth-1:0] imm;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd; // already the selected destination
  } idExT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic memWrite;
    logic memRead;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] storeData;
    logic [regAddrWidth-1:0] destReg;
  } exMemT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] readData;
    logic [regAddrWidth-1:0] destReg;
  } memWbT;

  typedef struct packed {
    logic valid;
    logic [imemAddrWidth-1:0] addr; // word index
    logic [dataWidth-1:0] instr;
  } progWriteT;

  typedef struct packed {
    logic valid;
    logic [regAddrWidth-1:0] regAddr;
    logic [dataWidth-1:0] value;
  } wbEventT;

  typedef struct packed {
    logic valid;
    logic [dataWidth-1:0] addr; // byte address
    logic [dataWidth-1:0] data;
  } storeEventT;

endpackage

// ==== stageReg.sv ====
module stageReg #(
  parameter type payloadT = logic
) (
  input logic clk,
  input logic reset,
  input logic hold,
  input logic flush,
  input payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0; // all-zero payload is a nop
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// ==== instrMem.sv ====
module instrMem (
  input logic clk,
  input mipsPkg::progWriteT progWrite,
  input logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] instr
);

  logic [mipsPkg::dataWidth-1:0] mem [mipsPkg::imemDepth] = '{default: '0};
  logic [mipsPkg::imemAddrWidth-1:0] fetchIdx;

  assign fetchIdx = pc[mipsPkg::imemAddrWidth+1:2]; // byte pc to word index

  always_ff @(posedge clk) begin
    if (progWrite.valid) begin
      mem[progWrite.addr] <= progWrite.instr;
    end
  end

  assign instr = mem[fetchIdx];

endmodule

// ==== controlUnit.sv ====
module controlUnit (
  input logic [mipsPkg::dataWidth-1:0] instr,
  output mipsPkg::ctrlT ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct = instr[5:0];

  always_comb begin
    ctrl = '0;
    case (opcode)
      mipsPkg::opR: begin
        case (funct)
          mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
          mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
          default: ctrl.aluOp = mipsPkg::aluAdd;
        endcase
        if (funct == mipsPkg::fnAdd || funct == mipsPkg::fnSub ||
            funct == mipsPkg::fnSlt) begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst = 1'b1; // write rd
        end
      end
      mipsPkg::opSlti: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp = mipsPkg::aluSlt;
      end
      mipsPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp = mipsPkg::aluAdd;
      end
      mipsPkg::opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp = mipsPkg::aluAdd;
      end
      mipsPkg::opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp = mipsPkg::aluSub; // equal when difference is zero
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== regFile.sv ====
module regFile (
  input logic clk,
  input logic reset,
  input logic [mipsPkg::regAddrWidth-1:0] rs,
  input logic [mipsPkg::regAddrWidth-1:0] rt,
  output logic [mipsPkg::dataWidth-1:0] rsData,
  output logic [mipsPkg::dataWidth-1:0] rtData,
  input logic wbEn,
  input logic [mipsPkg::regAddrWidth-1:0] wbReg,
  input logic [mipsPkg::dataWidth-1:0] wbData
);

  logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];
  logic wbLive;

  assign wbLive = wbEn && (wbReg != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wbLive) begin
      regs[wbReg] <= wbData;
    end
  end

  // r0 reads zero, same-cycle write passes through
  assign rsData = (rs == '0) ? '0 : (wbLive && wbReg == rs) ? wbData : regs[rs];
  assign rtData = (rt == '0) ? '0 : (wbLive && wbReg == rt) ? wbData : regs[rt];

endmodule

// ==== aluUnit.sv ====
module aluUnit (
  input mipsPkg::idExT idEx,
  input mipsPkg::fwdSelT fwdA,
  input mipsPkg::fwdSelT fwdB,
  input logic [mipsPkg::dataWidth-1:0] memResult,
  input logic [mipsPkg::dataWidth-1:0] wbResult,
  output mipsPkg::exMemT exMem,
  output logic branchTaken,
  output logic [mipsPkg::dataWidth-1:0] branchTarget
);

  logic [mipsPkg::dataWidth-1:0] opA;
  logic [mipsPkg::dataWidth-1:0] rtFwd;
  logic [mipsPkg::dataWidth-1:0] opB;
  logic [mipsPkg::dataWidth-1:0] result;

  function automatic logic [mipsPkg::dataWidth-1:0] pickOperand(
    input mipsPkg::fwdSelT sel,
    input logic [mipsPkg::dataWidth-1:0] regVal,
    input logic [mipsPkg::dataWidth-1:0] memVal,
    input logic [mipsPkg::dataWidth-1:0] wbVal
  );
    case (sel)
      mipsPkg::fwdMem: return memVal;
      mipsPkg::fwdWb: return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign opA = pickOperand(fwdA, idEx.rsData, memResult, wbResult);
  assign rtFwd = pickOperand(fwdB, idEx.rtData, memResult, wbResult);
  assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtFwd;

  always_comb begin
    case (idEx.ctrl.aluOp)
      mipsPkg::aluSub: result = opA - opB;
      mipsPkg::aluSlt: result = {{(mipsPkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
      default: result = opA + opB;
    endcase
  end

  assign branchTaken = idEx.ctrl.branch && (result == '0);
  assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[mipsPkg::dataWidth-3:0], 2'b00};

  always_comb begin
    exMem.regWrite = idEx.ctrl.regWrite;
    exMem.memToReg = idEx.ctrl.memToReg;
    exMem.memWrite = idEx.ctrl.memWrite;
    exMem.memRead = idEx.ctrl.memRead;
    exMem.aluResult = result;
    exMem.storeData = rtFwd; // forwarded rt for sw
    exMem.destReg = idEx.rd;
  end

endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
  input logic [mipsPkg::dataWidth-1:0] ifIdInstr,
  input mipsPkg::idExT idEx,
  input logic [mipsPkg::regAddrWidth-1:0] exMemDest,
  input logic exMemWrite,
  input logic [mipsPkg::regAddrWidth-1:0] memWbDest,
  input logic memWbWrite,
  input logic branchTaken,
  output mipsPkg::fwdSelT fwdA,
  output mipsPkg::fwdSelT fwdB,
  output logic stall,
  output logic flush
);

  logic [mipsPkg::regAddrWidth-1:0] ifIdRs;
  logic [mipsPkg::regAddrWidth-1:0] ifIdRt;
  logic memLive;
  logic wbLive;

  assign ifIdRs = ifIdInstr[25:21];
  assign ifIdRt = ifIdInstr[20:16];

  // r0 never forwarded
  assign memLive = exMemWrite && (exMemDest != '0);
  assign wbLive = memWbWrite && (memWbDest != '0);

  always_comb begin
    if (memLive && exMemDest == idEx.rs) begin
      fwdA = mipsPkg::fwdMem;
    end else if (wbLive && memWbDest == idEx.rs) begin
      fwdA = mipsPkg::fwdWb;
    end else begin
      fwdA = mipsPkg::fwdNone;
    end
  end

  always_comb begin
    if (memLive && exMemDest == idEx.rt) begin
      fwdB = mipsPkg::fwdMem;
    end else if (wbLive && memWbDest == idEx.rt) begin
      fwdB = mipsPkg::fwdWb;
    end else begin
      fwdB = mipsPkg::fwdNone;
    end
  end

  // load result not ready until MEM, hold one cycle
  assign stall = idEx.ctrl.memRead && (idEx.rt != '0) &&
                 (idEx.rt == ifIdRs || idEx.rt == ifIdRt);

  assign flush = branchTaken; // kills IF/ID and ID/EX

endmodule

// ==== dataMem.sv ====
module dataMem (
  input logic clk,
  input logic reset,
  input mipsPkg::exMemT exMem,
  output logic [mipsPkg::dataWidth-1:0] readData
);

  logic [mipsPkg::dataWidth-1:0] mem [mipsPkg::dmemDepth];
  logic [mipsPkg::dmemAddrWidth-1:0] wordIdx;

  assign wordIdx = exMem.aluResult[mipsPkg::dmemAddrWidth+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mipsPkg::dmemDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (exMem.memWrite) begin
      mem[wordIdx] <= exMem.storeData;
    end
  end

  assign readData = exMem.memRead ? mem[wordIdx] : '0;

endmodule

// ==== mipsPipeline.sv ====
module mipsPipeline (
  input logic clk,
  input logic reset,
  input mipsPkg::progWriteT progWrite,
  output mipsPkg::wbEventT wbEvent,
  output mipsPkg::storeEventT storeEvent
);

  logic [mipsPkg::dataWidth-1:0] pc;
  logic [mipsPkg::dataWidth-1:0] instr;
  logic [mipsPkg::dataWidth-1:0] branchTarget;
  logic [mipsPkg::dataWidth-1:0] rsData;
  logic [mipsPkg::dataWidth-1:0] rtData;
  logic [mipsPkg::dataWidth-1:0] readData;
  logic [mipsPkg::dataWidth-1:0] wbValue;
  logic stall;
  logic flush;
  logic branchTaken;
  mipsPkg::fwdSelT fwdA;
  mipsPkg::fwdSelT fwdB;
  mipsPkg::ctrlT ctrl;
  mipsPkg::ifIdT ifIdD;
  mipsPkg::ifIdT ifIdQ;
  mipsPkg::idExT idExD;
  mipsPkg::idExT idExQ;
  mipsPkg::exMemT exMemD;
  mipsPkg::exMemT exMemQ;
  mipsPkg::memWbT memWbD;
  mipsPkg::memWbT memWbQ;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (flush) begin
      pc <= branchTarget; // taken beq in EX
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  instrMem u_instrMem (.clk(clk), .progWrite(progWrite), .pc(pc), .instr(instr));

  always_comb begin
    ifIdD.pc = pc;
    ifIdD.instr = instr;
  end

  stageReg #(.payloadT(mipsPkg::ifIdT)) u_ifIdReg (
    .clk(clk), .reset(reset), .hold(stall), .flush(flush), .d(ifIdD), .q(ifIdQ)
  );

  controlUnit u_controlUnit (.instr(ifIdQ.instr), .ctrl(ctrl));

  regFile u_regFile (
    .clk(clk), .reset(reset),
    .rs(ifIdQ.instr[25:21]), .rt(ifIdQ.instr[20:16]),
    .rsData(rsData), .rtData(rtData),
    .wbEn(memWbQ.regWrite), .wbReg(memWbQ.destReg), .wbData(wbValue)
  );

  always_comb begin
    idExD.ctrl = ctrl;
    idExD.pc = ifIdQ.pc;
    idExD.rsData = rsData;
    idExD.rtData = rtData;
    idExD.imm = {{(mipsPkg::dataWidth-16){ifIdQ.instr[15]}}, ifIdQ.instr[15:0]};
    idExD.rs = ifIdQ.instr[25:21];
    idExD.rt = ifIdQ.instr[20:16];
    idExD.rd = ctrl.regDst ? ifIdQ.instr[15:11] : ifIdQ.instr[20:16]; // rd for R-type
  end

  // bubble on load-use, squash on taken branch
  stageReg #(.payloadT(mipsPkg::idExT)) u_idExReg (
    .clk(clk), .reset(reset), .hold(1'b0), .flush(stall || flush), .d(idExD), .q(idExQ)
  );

  aluUnit u_aluUnit (
    .idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB),
    .memResult(exMemQ.aluResult), .wbResult(wbValue),
    .exMem(exMemD), .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  hazardUnit u_hazardUnit (
    .ifIdInstr(ifIdQ.instr), .idEx(idExQ),
    .exMemDest(exMemQ.destReg), .exMemWrite(exMemQ.regWrite),
    .memWbDest(memWbQ.destReg), .memWbWrite(memWbQ.regWrite),
    .branchTaken(branchTaken),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
  );

  stageReg #(.payloadT(mipsPkg::exMemT)) u_exMemReg (
    .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  dataMem u_dataMem (.clk(clk), .reset(reset), .exMem(exMemQ), .readData(readData));

  always_comb begin
    memWbD.regWrite = exMemQ.regWrite;
    memWbD.memToReg = exMemQ.memToReg;
    memWbD.aluResult = exMemQ.aluResult;
    memWbD.readData = readData;
    memWbD.destReg = exMemQ.destReg;
  end

  stageReg #(.payloadT(mipsPkg::memWbT)) u_memWbReg (
    .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

  assign wbValue = memWbQ.memToReg ? memWbQ.readData : memWbQ.aluResult;

  always_comb begin
    wbEvent.valid = memWbQ.regWrite && (memWbQ.destReg != '0);
    wbEvent.regAddr = memWbQ.destReg;
    wbEvent.value = wbValue;
    storeEvent.valid = exMemQ.memWrite; // store retires in MEM
    storeEvent.addr = exMemQ.aluResult;
    storeEvent.data = exMemQ.storeData;
  end

endmodule

// ==== mipsTb.sv ====
module mipsTb;

  typedef logic [31:0] progQT[$];

  logic clk;
  logic reset;
  mipsPkg::progWriteT progWrite;
  mipsPkg::wbEventT wbEvent;
  mipsPkg::storeEventT storeEvent;

  mipsPkg::wbEventT expWb[$];
  mipsPkg::storeEventT expSt[$];
  string testName;
  int mismatches = 0;
  int otherErrors = 0;
  int globalCycles = 0;
  int totalLimit = 0;

  mipsPipeline u_mipsPipeline (
    .clk(clk), .reset(reset), .progWrite(progWrite),
    .wbEvent(wbEvent), .storeEvent(storeEvent)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] encR(logic [5:0] fn, int rd, int rs, int rt);
    return {mipsPkg::opR, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(logic [5:0] op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] haltInstr();
    return encI(mipsPkg::opBeq, 0, 0, -1); // beq r0,r0,-1
  endfunction

  // in-order ISA model that fills the expected event queues
  function automatic void runModel(input progQT prog);
    logic [31:0] regs [32];
    logic [31:0] mem [mipsPkg::dmemDepth];
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] val;
    logic [4:0] dest;
    logic writes;
    mipsPkg::wbEventT wb;
    mipsPkg::storeEventT st;
    int pc;
    int steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < mipsPkg::dmemDepth; i++) begin
      mem[i] = '0;
    end
    expWb.delete();
    expSt.delete();
    pc = 0;
    steps = 0;
    while (pc >= 0 && pc < prog.size() && steps < 1000) begin
      instr = prog[pc];
      if (instr == haltInstr()) begin
        break;
      end
      a = regs[instr[25:21]];
      b = regs[instr[20:16]];
      imm = {{16{instr[15]}}, instr[15:0]};
      addr = a + imm;
      val = '0;
      writes = 1'b0;
      dest = instr[20:16];
      pc++;
      steps++;
      case (instr[31:26])
        mipsPkg::opR: begin
          dest = instr[15:11];
          writes = 1'b1;
          case (instr[5:0])
            mipsPkg::fnAdd: val = a + b;
            mipsPkg::fnSub: val = a - b;
            mipsPkg::fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: writes = 1'b0; // unknown funct is a nop
          endcase
        end
        mipsPkg::opSlti: begin
          val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          writes = 1'b1;
        end
        mipsPkg::opLw: begin
          val = mem[addr[mipsPkg::dmemAddrWidth+1:2]];
          writes = 1'b1;
        end
        mipsPkg::opSw: begin
          mem[addr[mipsPkg::dmemAddrWidth+1:2]] = b;
          st.valid = 1'b1;
          st.addr = addr;
          st.data = b;
          expSt.push_back(st);
        end
        mipsPkg::opBeq: begin
          if (a == b) begin
            pc = pc + int'($signed(imm));
          end
        end
        default: writes = 1'b0;
      endcase
      if (writes && dest != 5'd0) begin
        regs[dest] = val;
        wb.valid = 1'b1;
        wb.regAddr = dest;
        wb.value = val;
        expWb.push_back(wb);
      end
    end
  endfunction

  function automatic int pickReg();
    return int'($urandom_range(7, 0)); // few regs for more hazards
  endfunction

  function automatic progQT randomProg(int len);
    progQT prog;
    int kind;
    int maxOff;
    for (int i = 0; i < len - 1; i++) begin
      kind = int'($urandom_range(6, 0));
      maxOff = (len - 2 - i < 3) ? len - 2 - i : 3; // target never past the halt
      case (kind)
        0: prog.push_back(encR(mipsPkg::fnAdd, pickReg(), pickReg(), pickReg()));
        1: prog.push_back(encR(mipsPkg::fnSub, pickReg(), pickReg(), pickReg()));
        2: prog.push_back(encR(mipsPkg::fnSlt, pickReg(), pickReg(), pickReg()));
        3: prog.push_back(encI(mipsPkg::opSlti, pickReg(), pickReg(),
                               int'($urandom_range(20, 0)) - 10));
        4: prog.push_back(encI(mipsPkg::opLw, pickReg(), 0, 4 * int'($urandom_range(7, 0))));
        5: prog.push_back(encI(mipsPkg::opSw, pickReg(), 0, 4 * int'($urandom_range(7, 0))));
        default: prog.push_back(encI(mipsPkg::opBeq, pickReg(), pickReg(),
                                     int'($urandom_range(maxOff, 0))));
      endcase
    end
    prog.push_back(haltInstr());
    return prog;
  endfunction

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
      mismatches++;
    end
  endtask

  task automatic finishRun();
    $display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // events come from registered stage state and are stable at the falling edge
  always @(negedge clk) begin
    mipsPkg::wbEventT expW;
    mipsPkg::storeEventT expS;
    if (wbEvent.valid) begin
      if (expWb.size() == 0) begin
        $display("%s: unexpected writeback of %h to r%0d", testName, wbEvent.value,
                 wbEvent.regAddr);
        otherErrors++;
      end else begin
        expW = expWb.pop_front();
        checkEq("wb reg", 32'(expW.regAddr), 32'(wbEvent.regAddr));
        checkEq("wb value", expW.value, wbEvent.value);
      end
    end
    if (storeEvent.valid) begin
      if (expSt.size() == 0) begin
        $display("%s: unexpected store of %h to %h", testName, storeEvent.data,
                 storeEvent.addr);
        otherErrors++;
      end else begin
        expS = expSt.pop_front();
        checkEq("store addr", expS.addr, storeEvent.addr);
        checkEq("store data", expS.data, storeEvent.data);
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      globalCycles++;
      if (globalCycles > totalLimit) begin
        $display("run stopped, %0d cycles is past the limit of all tests", globalCycles);
        otherErrors++;
        finishRun();
      end
    end
  end

  task automatic runTest(input string name, input progQT prog);
    int limit;
    int cycles;
    int doneAt;
    testName = name;
    runModel(prog);
    limit = 10 * prog.size() + 50;
    reset = 1'b1;
    foreach (prog[i]) begin
      progWrite.valid = 1'b1;
      progWrite.addr = i[mipsPkg::imemAddrWidth-1:0];
      progWrite.instr = prog[i];
      @(negedge clk);
    end
    progWrite = '0;
    repeat (8) @(negedge clk);
    totalLimit += limit;
    reset = 1'b0;
    cycles = 0;
    while ((expWb.size() != 0 || expSt.size() != 0) && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (expWb.size() != 0 || expSt.size() != 0) begin
      $display("%s: timed out after %0d cycles, %0d writebacks and %0d stores never seen",
               name, limit, expWb.size(), expSt.size());
      foreach (expWb[i]) begin
        $display("  missing writeback r%0d = %h", expWb[i].regAddr, expWb[i].value);
      end
      foreach (expSt[i]) begin
        $display("  missing store %h to %h", expSt[i].data, expSt[i].addr);
      end
      otherErrors++;
    end
    doneAt = cycles;
    while (cycles < limit && cycles < doneAt + 10) begin
      @(posedge clk); // catch stray events
      cycles++;
    end
    @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
  endtask

  initial begin
    progQT prog;
    reset = 1'b1;
    progWrite = '0;
    void'($urandom(32'h8b8a_3a67));

    prog = {encI(mipsPkg::opSlti, 1, 0, 5), encR(mipsPkg::fnAdd, 2, 1, 1),
            encR(mipsPkg::fnAdd, 3, 2, 2), encR(mipsPkg::fnSub, 4, 3, 1),
            encR(mipsPkg::fnSlt, 5, 4, 3), encR(mipsPkg::fnAdd, 6, 5, 4),
            encR(mipsPkg::fnSub, 7, 0, 6), encR(mipsPkg::fnSlt, 8, 7, 6),
            encR(mipsPkg::fnAdd, 9, 8, 7), encR(mipsPkg::fnSub, 10, 7, 9), haltInstr()};
    runTest("rChain", prog);

    prog = {encI(mipsPkg::opSlti, 1, 0, 1), encR(mipsPkg::fnSub, 2, 0, 1),
            encI(mipsPkg::opSlti, 3, 2, 0), encI(mipsPkg::opSlti, 4, 2, -2),
            encI(mipsPkg::opSlti, 5, 2, -1), encI(mipsPkg::opSlti, 6, 1, -5),
            encI(mipsPkg::opSlti, 7, 0, -1), encI(mipsPkg::opSlti, 8, 2, 7), haltInstr()};
    runTest("sltiSigned", prog);

    prog = {encI(mipsPkg::opSlti, 1, 0, 1), encR(mipsPkg::fnAdd, 2, 1, 1),
            encR(mipsPkg::fnAdd, 3, 2, 2), encI(mipsPkg::opSw, 3, 0, 8),
            encI(mipsPkg::opSw, 2, 0, 12), encI(mipsPkg::opLw, 4, 0, 8),
            encR(mipsPkg::fnAdd, 5, 4, 4), encI(mipsPkg::opLw, 6, 0, 12),
            encI(mipsPkg::opSw, 6, 0, 16), encI(mipsPkg::opLw, 7, 0, 16),
            encR(mipsPkg::fnSub, 8, 7, 1), encI(mipsPkg::opLw, 9, 3, 4),
            encI(mipsPkg::opLw, 10, 9, 4), haltInstr()};
    runTest("loadStore", prog);

    prog = {encI(mipsPkg::opSlti, 1, 0, 1), encI(mipsPkg::opBeq, 0, 1, 2),
            encR(mipsPkg::fnAdd, 2, 1, 1), encI(mipsPkg::opBeq, 1, 1, 2),
            encR(mipsPkg::fnAdd, 3, 1, 1), encR(mipsPkg::fnAdd, 4, 1, 1),
            encR(mipsPkg::fnAdd, 5, 2, 1), encI(mipsPkg::opBeq, 2, 5, 1),
            encI(mipsPkg::opSlti, 6, 5, 4), encI(mipsPkg::opBeq, 0, 0, 1),
            encR(mipsPkg::fnAdd, 7, 1, 1), haltInstr()};
    runTest("branches", prog);

    for (int p = 0; p < 2; p++) begin
      prog = randomProg(30);
      runTest($sformatf("random%0dFirst", p), prog);
      runTest($sformatf("random%0dSecond", p), prog); // same program after reset
    end

    finishRun();
  end

endmodule

// ==== mipsPipeline.f ====
mipsPkg.sv
stageReg.sv
instrMem.sv
controlUnit.sv
regFile.sv
aluUnit.sv
hazardUnit.sv
dataMem.sv
mipsPipeline.sv
mipsTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f mipsPipeline.f --top-module mipsTb -o mipsSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/mipsSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
fi
exit 1
